// File: Makefile
VERILATOR  ?= verilator
FILELIST   := verilog.f
TOP        := tb_adapter_dpb_ppfifo
RTL_TOP    := adapter_dpb_ppfifo
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing
OBJ_DIR    := obj_dir
PASS_MSG   := Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: adapter_dpb_ppfifo.sv
// Top level of the buffer to ping-pong FIFO adapter, connecting buffer, tracker, counter and FSM
`timescale 1ns/1ps

module adapter_dpb_ppfifo (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_ppfifo_2_mem_en,
  input  logic                       i_mem_2_ppfifo_stb,
  input  logic                       i_cancel_write_stb,
  input  dpb_pkg::bram_req_t         i_bram,
  output logic [dpb_pkg::DATA_W-1:0] o_bram_dout,
  output logic                       o_bram_valid,
  input  ppfifo_pkg::pf_wr_in_t      i_pf_wr,
  output ppfifo_pkg::pf_wr_out_t     o_pf_wr,
  input  ppfifo_pkg::pf_rd_in_t      i_pf_rd,
  output ppfifo_pkg::pf_rd_out_t     o_pf_rd,
  output logic [31:0]                o_num_reads,
  output logic                       o_idle
);

  logic                          clear;
  logic                          count_inc;
  logic                          addr_inc;
  logic                          size_sel;
  logic                          done;
  logic                          b_we;
  logic [dpb_pkg::ADDR_W-1:0]    b_addr;
  logic [dpb_pkg::DATA_W-1:0]    b_dout;
  logic [ppfifo_pkg::SIZE_W-1:0] xfer_size;

  // Bank size of the active direction
  assign xfer_size = size_sel ? i_pf_rd.size : i_pf_wr.size;

  // FIFO write data comes straight off port B
  assign o_pf_wr.data = b_dout;

  dpb local_buffer (
    .clk      (clk),
    .i_a      (i_bram),
    .o_a_dout (o_bram_dout),
    .i_b_we   (b_we),
    .i_b_addr (b_addr),
    .i_b_din  (i_pf_rd.data),
    .o_b_dout (b_dout)
  );

  bram_valid_tracker valid_tracker (
    .clk     (clk),
    .rst     (rst),
    .i_addr  (i_bram.addr),
    .o_valid (o_bram_valid)
  );

  xfer_counter counter (
    .clk         (clk),
    .rst         (rst),
    .i_clear     (clear),
    .i_count_inc (count_inc),
    .i_addr_inc  (addr_inc),
    .i_size      (xfer_size),
    .o_addr      (b_addr),
    .o_done      (done)
  );

  adapter_fsm fsm (
    .clk           (clk),
    .rst           (rst),
    .i_cancel      (i_cancel_write_stb),
    .i_wr_go       (i_mem_2_ppfifo_stb),
    .i_rd_en       (i_ppfifo_2_mem_en),
    .i_pf_wr       (i_pf_wr),
    .i_pf_rd_ready (i_pf_rd.ready),
    .i_done        (done),
    .o_clear       (clear),
    .o_count_inc   (count_inc),
    .o_addr_inc    (addr_inc),
    .o_size_sel    (size_sel),
    .o_b_we        (b_we),
    .o_wr_activate (o_pf_wr.activate),
    .o_wr_stb      (o_pf_wr.stb),
    .o_rd_stb      (o_pf_rd.stb),
    .o_rd_activate (o_pf_rd.activate),
    .o_num_reads   (o_num_reads),
    .o_idle        (o_idle)
  );

endmodule

// File: adapter_fsm.sv
// Sequencer for buffer-to-FIFO and FIFO-to-buffer transfers, steering the counter and port B
`timescale 1ns/1ps

module adapter_fsm (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_cancel,
  input  logic                      i_wr_go,
  input  logic                      i_rd_en,
  input  ppfifo_pkg::pf_wr_in_t     i_pf_wr,
  input  logic                      i_pf_rd_ready,
  input  logic                      i_done,
  output logic                      o_clear,
  output logic                      o_count_inc,
  output logic                      o_addr_inc,
  output logic                      o_size_sel,
  output logic                      o_b_we,
  output logic [1:0]                o_wr_activate,
  output logic                      o_wr_stb,
  output logic                      o_rd_stb,
  output logic                      o_rd_activate,
  output logic [31:0]               o_num_reads,
  output logic                      o_idle
);

  ppfifo_pkg::adapter_state_t state;
  logic                       bank_free;

  assign o_idle = (state == ppfifo_pkg::IDLE);

  // Counter and address restart whenever the adapter sits idle or is cancelled
  assign o_clear = i_cancel || o_idle;

  // Read transfers use the read-side bank size
  assign o_size_sel = (state == ppfifo_pkg::READ);

  // Some bank ready and none already held
  assign bank_free = (|i_pf_wr.ready) && !(|o_wr_activate);

  always_comb begin
    o_count_inc = 1'b0;
    o_addr_inc  = 1'b0;
    case (state)
      ppfifo_pkg::WRITE: begin
        // Address runs one ahead of the registered strobe
        o_count_inc = !i_done;
        o_addr_inc  = !i_done;
      end
      ppfifo_pkg::READ: begin
        o_count_inc = o_b_we && !i_done;
        // Address follows each pop by one cycle
        o_addr_inc  = o_rd_stb;
      end
      default: begin
        o_count_inc = 1'b0;
        o_addr_inc  = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    // Strobes and the port B write are single-cycle pulses
    o_wr_stb <= 1'b0;
    o_rd_stb <= 1'b0;
    o_b_we   <= 1'b0;
    if (rst || i_cancel) begin
      state         <= ppfifo_pkg::IDLE;
      o_wr_activate <= '0;
      o_rd_activate <= 1'b0;
      o_num_reads   <= '0;
    end else begin
      case (state)
        ppfifo_pkg::IDLE: begin
          o_wr_activate <= '0;
          o_rd_activate <= 1'b0;
          // Write strobe has priority over the read enable
          if (i_wr_go) begin
            state <= ppfifo_pkg::WRITE_SETUP;
          end else if (i_rd_en && i_pf_rd_ready) begin
            o_rd_activate <= 1'b1;
            state         <= ppfifo_pkg::READ;
          end
        end
        ppfifo_pkg::WRITE_SETUP: begin
          if (bank_free) begin
            // Bank 0 preferred
            o_wr_activate <= i_pf_wr.ready[0] ? 2'b01 : 2'b10;
            state         <= ppfifo_pkg::WRITE;
          end
        end
        ppfifo_pkg::WRITE: begin
          if (!i_done) begin
            o_wr_stb <= 1'b1;
          end else begin
            o_wr_activate <= '0;
            state         <= ppfifo_pkg::IDLE;
          end
        end
        ppfifo_pkg::READ: begin
          // Head word lands in the buffer before each pop
          o_b_we <= 1'b1;
          if (o_b_we) begin
            if (!i_done) begin
              o_rd_stb <= 1'b1;
            end else begin
              o_num_reads   <= o_num_reads + 1'b1;
              o_rd_activate <= 1'b0;
              o_b_we        <= 1'b0;
              state         <= ppfifo_pkg::IDLE;
            end
          end
        end
        default: begin
          state <= ppfifo_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

// File: bram_valid_tracker.sv
// Flags user read data valid once the user address has held steady for the wait time
`timescale 1ns/1ps

module bram_valid_tracker (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [dpb_pkg::ADDR_W-1:0] i_addr,
  output logic                       o_valid
);

  logic [dpb_pkg::ADDR_W-1:0] prev_addr;
  logic [dpb_pkg::WAIT_W-1:0] wait_count;
  logic                       addr_same;

  assign addr_same = (prev_addr == i_addr);

  // Count is the number of cycles the current address has been seen
  always_ff @(posedge clk) begin
    if (rst) begin
      prev_addr  <= '0;
      wait_count <= dpb_pkg::WAIT_W'(dpb_pkg::MEM_WAIT);
    end else if (!addr_same) begin
      // New address counts as its first cycle
      prev_addr  <= i_addr;
      wait_count <= dpb_pkg::WAIT_W'(1);
    end else if (wait_count < dpb_pkg::WAIT_W'(dpb_pkg::MEM_WAIT)) begin
      wait_count <= wait_count + 1'b1;
    end
  end

  assign o_valid = addr_same && (wait_count == dpb_pkg::WAIT_W'(dpb_pkg::MEM_WAIT));

endmodule

// File: dpb.sv
// Dual-port block buffer, user request on port A and FIFO traffic on port B
`timescale 1ns/1ps

module dpb (
  input  logic                         clk,
  input  dpb_pkg::bram_req_t           i_a,
  output logic [dpb_pkg::DATA_W-1:0]   o_a_dout,
  input  logic                         i_b_we,
  input  logic [dpb_pkg::ADDR_W-1:0]   i_b_addr,
  input  logic [dpb_pkg::DATA_W-1:0]   i_b_din,
  output logic [dpb_pkg::DATA_W-1:0]   o_b_dout
);

  logic [dpb_pkg::DATA_W-1:0] mem [dpb_pkg::DEPTH];

  // Both ports share one process so the array has a single driver
  always_ff @(posedge clk) begin
    if (i_a.we) begin
      mem[i_a.addr] <= i_a.din;
    end
    // Port B wins on a same-address collision
    if (i_b_we) begin
      mem[i_b_addr] <= i_b_din;
    end
  end

  // Registered reads, old data on a same-cycle write
  always_ff @(posedge clk) begin
    o_a_dout <= mem[i_a.addr];
  end

  always_ff @(posedge clk) begin
    o_b_dout <= mem[i_b_addr];
  end

endmodule

// File: dpb_pkg.sv
// Buffer widths, user-port timing and request type for the block buffer side
package dpb_pkg;

  // Buffer geometry
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int DEPTH  = 2 ** ADDR_W;

  // Stable-address cycles before user read data counts as valid
  localparam int MEM_WAIT = 2;

  // Width of the stable-cycle counter, wide enough to hold MEM_WAIT
  localparam int WAIT_W = $clog2(MEM_WAIT + 1);

  // One user-port request, applied every cycle
  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] din;
  } bram_req_t;

endpackage

// File: ppfifo_pkg.sv
// Ping-pong FIFO handshake types and the adapter state type, shared by the adapter modules
package ppfifo_pkg;

  // Bank size and transfer count width
  localparam int SIZE_W = 24;

  // Number of banks on the write side
  localparam int NUM_BANKS = 2;

  // Write side, status from the FIFO
  typedef struct packed {
    logic [NUM_BANKS-1:0] ready;
    logic [SIZE_W-1:0]    size;
  } pf_wr_in_t;

  // Write side, driven by the adapter
  typedef struct packed {
    logic [NUM_BANKS-1:0]       activate;
    logic                       stb;
    logic [dpb_pkg::DATA_W-1:0] data;
  } pf_wr_out_t;

  // Read side, head word and status from the FIFO
  typedef struct packed {
    logic                       ready;
    logic [SIZE_W-1:0]          size;
    logic [dpb_pkg::DATA_W-1:0] data;
  } pf_rd_in_t;

  // Read side, driven by the adapter
  typedef struct packed {
    logic activate;
    logic stb;
  } pf_rd_out_t;

  // Adapter sequencing states
  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    WRITE_SETUP = 2'd1,
    WRITE       = 2'd2,
    READ        = 2'd3
  } adapter_state_t;

endpackage

// File: tb_adapter_dpb_ppfifo.sv
// Directed testbench for the adapter with FIFO models on both sides, built and run by the Makefile
`timescale 1ns/1ps

module tb_adapter_dpb_ppfifo;

  localparam int TIMEOUT = 200;

  logic                          clk;
  logic                          rst;
  logic                          rd_en;
  logic                          wr_go;
  logic                          cancel;
  dpb_pkg::bram_req_t            bram_req;
  logic [dpb_pkg::DATA_W-1:0]    bram_dout;
  logic                          bram_valid;
  ppfifo_pkg::pf_wr_in_t         pf_wr_in;
  ppfifo_pkg::pf_wr_out_t        pf_wr_out;
  ppfifo_pkg::pf_rd_in_t         pf_rd_in;
  ppfifo_pkg::pf_rd_out_t        pf_rd_out;
  logic [31:0]                   num_reads;
  logic                          idle;

  // Read-side source fields
  logic                          rd_ready;
  logic [ppfifo_pkg::SIZE_W-1:0] rd_size;
  logic [dpb_pkg::DATA_W-1:0]    rd_data = '0;

  logic [dpb_pkg::DATA_W-1:0]    rd_queue[$];
  logic [dpb_pkg::DATA_W-1:0]    sink_words[$];
  // Expected buffer contents
  logic [dpb_pkg::DATA_W-1:0]    exp_mem [dpb_pkg::DEPTH];
  // Completed reads since reset or the last cancel
  logic [31:0]                   exp_num_reads;
  int                            check_count;
  int                            error_count;

  assign pf_rd_in = '{ready: rd_ready, size: rd_size, data: rd_data};

  adapter_dpb_ppfifo dut0 (
    .clk                (clk),
    .rst                (rst),
    .i_ppfifo_2_mem_en  (rd_en),
    .i_mem_2_ppfifo_stb (wr_go),
    .i_cancel_write_stb (cancel),
    .i_bram             (bram_req),
    .o_bram_dout        (bram_dout),
    .o_bram_valid       (bram_valid),
    .i_pf_wr            (pf_wr_in),
    .o_pf_wr            (pf_wr_out),
    .i_pf_rd            (pf_rd_in),
    .o_pf_rd            (pf_rd_out),
    .o_num_reads        (num_reads),
    .o_idle             (idle)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Write-side sink, one word per strobe while a bank is active
  always @(posedge clk) begin
    if ((|pf_wr_out.activate) && pf_wr_out.stb) begin
      sink_words.push_back(pf_wr_out.data);
    end
  end

  // Read-side source, next head word shows up the cycle after a pop
  always @(posedge clk) begin
    if (pf_rd_out.stb && rd_queue.size() > 0) begin
      void'(rd_queue.pop_front());
    end
    rd_data <= (rd_queue.size() > 0) ? rd_queue[0] : '0;
  end

  task automatic compare_data(input string name, input logic [dpb_pkg::DATA_W-1:0] got,
                              input logic [dpb_pkg::DATA_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic compare_count(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic compare_bits(input string name, input logic [ppfifo_pkg::NUM_BANKS-1:0] got,
                              input logic [ppfifo_pkg::NUM_BANKS-1:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    error_count++;
    $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
  endtask

  task automatic wait_wr_active(input logic want);
    int n;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      if ((|pf_wr_out.activate) == want) break;
    end
    if ((|pf_wr_out.activate) != want) report_timeout("write activate change");
  endtask

  task automatic wait_rd_active(input logic want);
    int n;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      if (pf_rd_out.activate == want) break;
    end
    if (pf_rd_out.activate != want) report_timeout("read activate change");
  endtask

  task automatic wait_idle();
    int n;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      if (idle) break;
    end
    if (!idle) report_timeout("o_idle");
  endtask

  // Cycles is the count of sampled cycles before valid was seen
  task automatic wait_valid(output int cycles);
    int n;
    cycles = 0;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      cycles = n;
      if (bram_valid) break;
    end
    if (!bram_valid) report_timeout("o_bram_valid");
  endtask

  task automatic wait_sink_count(input int count);
    int n;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      if (sink_words.size() >= count) break;
    end
    if (sink_words.size() < count) report_timeout("words at the write-side sink");
  endtask

  task automatic pulse_write_go();
    @(posedge clk);
    wr_go <= 1'b1;
    @(posedge clk);
    wr_go <= 1'b0;
  endtask

  task automatic pulse_cancel();
    @(posedge clk);
    cancel <= 1'b1;
    @(posedge clk);
    cancel <= 1'b0;
  endtask

  task automatic user_write(input logic [dpb_pkg::ADDR_W-1:0] addr,
                            input logic [dpb_pkg::DATA_W-1:0] data);
    @(posedge clk);
    bram_req <= '{we: 1'b1, addr: addr, din: data};
    exp_mem[addr] = data;
  endtask

  task automatic user_write_stop();
    @(posedge clk);
    bram_req.we <= 1'b0;
  endtask

  task automatic user_read_check(input logic [dpb_pkg::ADDR_W-1:0] addr,
                                 input logic [dpb_pkg::DATA_W-1:0] exp);
    logic changed;
    int   latency;
    changed = (addr != bram_req.addr);
    @(posedge clk);
    bram_req <= '{we: 1'b0, addr: addr, din: '0};
    wait_valid(latency);
    // Fresh address stays invalid until it has been stable for the wait time
    if (changed) begin
      compare_count("o_bram_valid latency", latency, dpb_pkg::MEM_WAIT);
    end
    compare_data($sformatf("o_bram_dout[0x%02h]", addr), bram_dout, exp);
  endtask

  // Random words into buffer addresses 0 to count-1
  task automatic fill_buffer(input int count);
    int i;
    for (i = 0; i < count; i++) begin
      user_write(dpb_pkg::ADDR_W'(i), $urandom);
    end
    user_write_stop();
  endtask

  task automatic run_write_transfer(input logic [1:0] ready, input int size,
                                    input logic [1:0] exp_bank);
    int i;
    sink_words.delete();
    @(posedge clk);
    pf_wr_in <= '{ready: ready, size: ppfifo_pkg::SIZE_W'(size)};
    pulse_write_go();
    wait_wr_active(1'b1);
    compare_bits("o_pf_wr.activate", pf_wr_out.activate, exp_bank);
    wait_wr_active(1'b0);
    wait_idle();
    compare_count("write word count", sink_words.size(), size);
    for (i = 0; i < size && i < sink_words.size(); i++) begin
      compare_data($sformatf("o_pf_wr.data[%0d]", i), sink_words[i], exp_mem[i]);
    end
    @(posedge clk);
    pf_wr_in.ready <= '0;
  endtask

  task automatic test_reset_state();
    compare_bits("o_pf_wr.activate", pf_wr_out.activate, 2'b00);
    compare_bits("o_pf_rd.activate", {1'b0, pf_rd_out.activate}, 2'b00);
    compare_bits("strobes", {pf_wr_out.stb, pf_rd_out.stb}, 2'b00);
    compare_count("o_num_reads", num_reads, 32'd0);
    compare_bits("o_idle", {1'b0, idle}, 2'b01);
  endtask

  task automatic test_user_port();
    logic [dpb_pkg::ADDR_W-1:0] addrs [16];
    int i;
    // High nibble keeps the addresses distinct
    for (i = 0; i < 16; i++) begin
      addrs[i] = {4'(i), 4'($urandom)};
      user_write(addrs[i], $urandom);
    end
    user_write_stop();
    for (i = 0; i < 16; i++) begin
      user_read_check(addrs[i], exp_mem[addrs[i]]);
    end
  endtask

  task automatic test_buffer_to_fifo();
    fill_buffer(12);
    run_write_transfer(2'b11, 12, 2'b01);
    run_write_transfer(2'b10, 7, 2'b10);
  endtask

  task automatic test_fifo_to_buffer();
    int i;
    @(negedge clk);
    for (i = 0; i < 10; i++) begin
      rd_queue.push_back($urandom);
      exp_mem[i] = rd_queue[i];
    end
    @(posedge clk);
    rd_size  <= ppfifo_pkg::SIZE_W'(10);
    rd_ready <= 1'b1;
    rd_en    <= 1'b1;
    wait_rd_active(1'b1);
    // One transfer only
    @(posedge clk);
    rd_en    <= 1'b0;
    rd_ready <= 1'b0;
    wait_rd_active(1'b0);
    wait_idle();
    exp_num_reads = exp_num_reads + 32'd1;
    compare_count("o_num_reads", num_reads, exp_num_reads);
    compare_count("words left in read FIFO", rd_queue.size(), 32'd0);
    for (i = 0; i < 10; i++) begin
      user_read_check(dpb_pkg::ADDR_W'(i), exp_mem[i]);
    end
  endtask

  task automatic test_cancel();
    fill_buffer(20);
    sink_words.delete();
    @(posedge clk);
    pf_wr_in <= '{ready: 2'b01, size: ppfifo_pkg::SIZE_W'(20)};
    pulse_write_go();
    wait_wr_active(1'b1);
    wait_sink_count(5);
    pulse_cancel();
    // Cancel acts on the edge that samples it, like a synchronous reset
    @(negedge clk);
    compare_bits("o_pf_wr.activate", pf_wr_out.activate, 2'b00);
    compare_bits("o_pf_rd.activate", {1'b0, pf_rd_out.activate}, 2'b00);
    compare_bits("o_idle", {1'b0, idle}, 2'b01);
    exp_num_reads = '0;
    compare_count("o_num_reads", num_reads, exp_num_reads);
    // Full transfer after the cancel
    run_write_transfer(2'b01, 20, 2'b01);
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, error_count - errors_before);
    end
  endtask

  initial begin
    int errors_before;
    check_count   = 0;
    error_count   = 0;
    exp_num_reads = '0;
    void'($urandom(32'h2e3dda38));
    rst      <= 1'b1;
    rd_en    <= 1'b0;
    wr_go    <= 1'b0;
    cancel   <= 1'b0;
    bram_req <= '0;
    pf_wr_in <= '0;
    rd_ready <= 1'b0;
    rd_size  <= '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    errors_before = error_count;
    test_reset_state();
    report_test("reset state", errors_before);

    errors_before = error_count;
    test_user_port();
    report_test("user port", errors_before);

    errors_before = error_count;
    test_buffer_to_fifo();
    report_test("buffer to FIFO", errors_before);

    errors_before = error_count;
    test_fifo_to_buffer();
    report_test("FIFO to buffer", errors_before);

    errors_before = error_count;
    test_cancel();
    report_test("cancel", errors_before);

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
dpb_pkg.sv
ppfifo_pkg.sv
dpb.sv
bram_valid_tracker.sv
xfer_counter.sv
adapter_fsm.sv
adapter_dpb_ppfifo.sv
tb_adapter_dpb_ppfifo.sv

// File: xfer_counter.sv
// Transfer word counter and port B address for the adapter, with a done flag against the size
`timescale 1ns/1ps

module xfer_counter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          i_clear,
  input  logic                          i_count_inc,
  input  logic                          i_addr_inc,
  input  logic [ppfifo_pkg::SIZE_W-1:0] i_size,
  output logic [dpb_pkg::ADDR_W-1:0]    o_addr,
  output logic                          o_done
);

  logic [ppfifo_pkg::SIZE_W-1:0] count;

  // Words strobed so far in the current transfer
  always_ff @(posedge clk) begin
    if (rst || i_clear) begin
      count <= '0;
    end else if (i_count_inc) begin
      count <= count + 1'b1;
    end
  end

  // Port B address, advanced on its own since reads lag the strobe
  always_ff @(posedge clk) begin
    if (rst || i_clear) begin
      o_addr <= '0;
    end else if (i_addr_inc) begin
      o_addr <= o_addr + 1'b1;
    end
  end

  // Greater-or-equal also covers a zero-size bank
  assign o_done = (count >= i_size);

endmodule
